// File: hdl/knight_cmd_pkg.sv
package knight_cmd_pkg;

  localparam int CMD_W      = 16;         // Host command word
  localparam int OP_W       = 4;          // Opcode field in the top nibble
  localparam int HDG_BYTE_W = 8;          // Heading byte, bits 11..4
  localparam int SQ_W       = 4;          // Square count, bits 3..0
  localparam int ADDR_W     = 2;          // Wishbone word address

  typedef enum logic [OP_W-1:0] {
    OP_CAL     = 4'h2,                    // Gyro calibration
    OP_MOVE    = 4'h4,                    // Plain move
    OP_FANFARE = 4'h5,                    // Move with fanfare at the end
    OP_TOUR    = 4'h6                     // Hand off to the tour sequencer
  } op_e;

  typedef enum logic [ADDR_W-1:0] {
    REG_CMD    = 2'd0,
    REG_STATUS = 2'd1,
    REG_RAMP   = 2'd2,
    REG_NUDGE  = 2'd3
  } reg_addr_e;

  localparam int ST_PENDING   = 0;        // STATUS bits
  localparam int ST_RESP_DONE = 1;
  localparam int ST_REJECT    = 2;

  localparam int RAMP_INC_LSB = 0;        // inc_step in the low byte of RAMP
  localparam int RAMP_DEC_LSB = 8;        // dec_step in the high byte

  function automatic op_e cmd_op(input logic [CMD_W-1:0] cmd);
    return op_e'(cmd[CMD_W-1 -: OP_W]);
  endfunction

  function automatic logic [HDG_BYTE_W-1:0] cmd_heading(input logic [CMD_W-1:0] cmd);
    return cmd[SQ_W +: HDG_BYTE_W];
  endfunction

  function automatic logic [SQ_W-1:0] cmd_squares(input logic [CMD_W-1:0] cmd);
    return cmd[SQ_W-1:0];
  endfunction

endpackage

// File: hdl/knight_motion_pkg.sv
package knight_motion_pkg;

  localparam int STEP_W  = 8;             // Ramp step width
  localparam int NUDGE_W = 11;            // Nudge and threshold width

  localparam logic [NUDGE_W-1:0] ERR_THRESH_RST = 11'd44;  // Heading must settle below this

  typedef struct packed {
    logic [STEP_W-1:0]  inc_step;         // Speed added per heading sample
    logic [STEP_W-1:0]  dec_step;         // Speed removed per heading sample
    logic [NUDGE_W-1:0] nudge;            // Magnitude added or removed by side IR
    logic [NUDGE_W-1:0] err_thresh;       // Start threshold on |error|
  } motion_cfg_t;

  // Field tuning used by the real robot
  localparam motion_cfg_t CFG_RST = '{
    inc_step:   8'h03,
    dec_step:   8'h06,
    nudge:      11'h05F,
    err_thresh: ERR_THRESH_RST
  };

endpackage

// File: hdl/cmd_if.sv
`timescale 1ns/1ps

interface cmd_if;
  import knight_cmd_pkg::*;
  import knight_motion_pkg::*;

  logic [CMD_W-1:0] cmd;                  // Last accepted host command
  logic             cmd_rdy;              // Command pending
  logic             clr_cmd_rdy;          // Processor took the command
  logic             send_resp;            // Processor finished, pulse
  motion_cfg_t      cfg;                  // Ramp and heading tuning

  modport regs (
    output cmd, cmd_rdy, cfg,
    input  clr_cmd_rdy, send_resp
  );

  modport proc (
    input  cmd, cmd_rdy, cfg,
    output clr_cmd_rdy, send_resp
  );

endinterface

// File: hdl/motion_cfg_regs.sv
`timescale 1ns/1ps

module motion_cfg_regs (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic                             wb_cyc,
  input  logic                             wb_stb,
  input  logic                             wb_we,
  input  logic [knight_cmd_pkg::ADDR_W-1:0] wb_adr,
  input  logic [knight_cmd_pkg::CMD_W-1:0]  wb_dat_w,
  output logic [knight_cmd_pkg::CMD_W-1:0]  wb_dat_r,
  output logic                             wb_ack,
  input  logic                             reject,
  cmd_if.regs                              bus
);
  import knight_cmd_pkg::*;
  import knight_motion_pkg::*;

  logic             access;               // New cycle, not yet acked
  logic             wr_en;
  reg_addr_e        addr;
  logic             resp_done;            // Sticky, W1C
  logic             reject_q;             // Sticky alongside resp_done
  motion_cfg_t      cfg_q;
  logic [CMD_W-1:0] rd_data;

  assign access = wb_cyc & wb_stb & ~wb_ack;
  assign wr_en  = access & wb_we;
  assign addr   = reg_addr_e'(wb_adr);

  //////////////////////////////
  // Bus handshake
  //////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      wb_ack <= 1'b0;
    else
      wb_ack <= access;                   // One cycle after cyc/stb seen
  end

  always_ff @(posedge clk) begin
    if (access && !wb_we)
      wb_dat_r <= rd_data;                // Valid together with ack
  end

  always_comb begin
    rd_data = '0;
    case (addr)
      REG_CMD:    rd_data = bus.cmd;
      REG_STATUS: begin
        rd_data[ST_PENDING]   = bus.cmd_rdy;
        rd_data[ST_RESP_DONE] = resp_done;
        rd_data[ST_REJECT]    = reject_q;
      end
      REG_RAMP: begin
        rd_data[RAMP_INC_LSB +: STEP_W] = cfg_q.inc_step;
        rd_data[RAMP_DEC_LSB +: STEP_W] = cfg_q.dec_step;
      end
      default:    rd_data[NUDGE_W-1:0] = cfg_q.nudge;
    endcase
  end

  //////////////////////////////
  // Command and status
  //////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      bus.cmd_rdy <= 1'b0;
    else if (bus.clr_cmd_rdy)
      bus.cmd_rdy <= 1'b0;                // Low the cycle after the take
    else if (wr_en && addr == REG_CMD)
      bus.cmd_rdy <= 1'b1;
  end

  always_ff @(posedge clk) begin
    if (wr_en && addr == REG_CMD && !bus.cmd_rdy)
      bus.cmd <= wb_dat_w;                // Write while pending is dropped
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      resp_done <= 1'b0;
      reject_q  <= 1'b0;
    end else if (bus.send_resp) begin
      resp_done <= 1'b1;                  // Completion wins over a clear
      reject_q  <= reject;
    end else if (wr_en && addr == REG_STATUS && wb_dat_w[ST_RESP_DONE]) begin
      resp_done <= 1'b0;
      reject_q  <= 1'b0;
    end
  end

  //////////////////////////////
  // Tuning
  //////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      cfg_q <= CFG_RST;                   // err_thresh only ever takes this value
    else if (wr_en && addr == REG_RAMP) begin
      cfg_q.inc_step <= wb_dat_w[RAMP_INC_LSB +: STEP_W];
      cfg_q.dec_step <= wb_dat_w[RAMP_DEC_LSB +: STEP_W];
    end else if (wr_en && addr == REG_NUDGE)
      cfg_q.nudge <= wb_dat_w[NUDGE_W-1:0];
  end

  assign bus.cfg = cfg_q;

  ack_single: assert property (@(posedge clk) disable iff (!rst_n) wb_ack |=> !wb_ack);

  // A pending command holds until the processor takes it
  pending_held: assert property (@(posedge clk) disable iff (!rst_n)
    bus.cmd_rdy && !bus.clr_cmd_rdy |=> bus.cmd_rdy && $stable(bus.cmd));

endmodule

// File: hdl/ir_sync.sv
`timescale 1ns/1ps

module ir_sync #(
  parameter int SYNC_STAGES = 2
) (
  input  logic clk,
  input  logic rst_n,
  input  logic lft_ir,
  input  logic cntr_ir,
  input  logic rght_ir,
  output logic lft_sync,
  output logic rght_sync,
  output logic cntr_rise
);

  localparam int LFT  = 2;                // Bit positions in each stage
  localparam int CNTR = 1;
  localparam int RGHT = 0;

  logic [SYNC_STAGES-1:0][2:0] sync_q;    // Stage 0 samples the pins
  logic                        cntr_prev; // For edge detect

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sync_q    <= '0;
      cntr_prev <= 1'b0;
    end else begin
      sync_q    <= {sync_q[SYNC_STAGES-2:0], {lft_ir, cntr_ir, rght_ir}};
      cntr_prev <= sync_q[SYNC_STAGES-1][CNTR];
    end
  end

  assign lft_sync  = sync_q[SYNC_STAGES-1][LFT];
  assign rght_sync = sync_q[SYNC_STAGES-1][RGHT];

  // One pulse per line crossing
  assign cntr_rise = sync_q[SYNC_STAGES-1][CNTR] & ~cntr_prev;

endmodule

// File: hdl/cmd_proc.sv
`timescale 1ns/1ps

module cmd_proc #(
  parameter int HEADING_W = 12,
  parameter int SPD_W     = 10
) (
  input  logic                        clk,
  input  logic                        rst_n,
  cmd_if.proc                         bus,
  input  logic                        cal_done,
  input  logic signed [HEADING_W-1:0] heading,
  input  logic                        heading_rdy,
  input  logic                        lft_sync,
  input  logic                        rght_sync,
  input  logic                        cntr_rise,
  output logic                        strt_cal,
  output logic                        moving,
  output logic                        tour_go,
  output logic                        fanfare_go,
  output logic                        reject,
  output logic signed [HEADING_W-1:0] error,
  output logic        [SPD_W-1:0]     frwrd
);
  import knight_cmd_pkg::*;
  import knight_motion_pkg::*;

  typedef enum logic [2:0] {S_IDLE, S_CAL, S_ALIGN, S_RAMP_UP, S_RAMP_DN} state_e;

  state_e                      state, nxt_state;
  op_e                         op_cur;    // Opcode of the pending command
  op_e                         op_q;      // Opcode of the command in progress
  logic [HDG_BYTE_W-1:0]       hdg_byte;
  logic signed [HEADING_W-1:0] desired_q;
  logic [SQ_W-1:0]             squares_q;
  logic [SQ_W:0]               rise_cnt;  // Up to twice the square count
  logic                        accept;
  logic                        move_done;
  logic                        max_spd;
  logic                        spd_zero;
  logic                        clr_frwrd;
  logic [SPD_W:0]              spd_sum;   // Carry out flags saturation
  logic [SPD_W-1:0]            dec_ext;
  logic signed [HEADING_W-1:0] nudge_ext;
  logic signed [HEADING_W-1:0] err_nudge;
  logic [HEADING_W-1:0]        err_abs;

  assign op_cur   = cmd_op(bus.cmd);
  assign hdg_byte = cmd_heading(bus.cmd);
  assign accept   = (state == S_IDLE) && bus.cmd_rdy;

  //////////////////////////////
  // Command latch and squares
  //////////////////////////////
  always_ff @(posedge clk) begin
    if (accept) begin
      op_q      <= op_cur;
      squares_q <= cmd_squares(bus.cmd);
      desired_q <= (hdg_byte == '0) ? '0 : {hdg_byte, {(HEADING_W-HDG_BYTE_W){1'b1}}};
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      rise_cnt <= '0;
    else if (accept)
      rise_cnt <= '0;                     // Fresh count per command
    else if (state == S_RAMP_UP && cntr_rise)
      rise_cnt <= rise_cnt + 1'b1;
  end

  assign move_done = (rise_cnt == {squares_q, 1'b0});  // Two crossings per square

  //////////////////////////////
  // Forward speed
  //////////////////////////////
  assign spd_sum  = {1'b0, frwrd} + (SPD_W+1)'(bus.cfg.inc_step);
  assign dec_ext  = SPD_W'(bus.cfg.dec_step);
  assign max_spd  = &frwrd[SPD_W-1 -: 2];
  assign spd_zero = (frwrd == '0);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      frwrd <= '0;
    else if (clr_frwrd)
      frwrd <= '0;
    else if (heading_rdy && state == S_RAMP_UP && !max_spd)
      frwrd <= spd_sum[SPD_W] ? '1 : spd_sum[SPD_W-1:0];  // Clamp at full scale
    else if (heading_rdy && state == S_RAMP_DN)
      frwrd <= (frwrd > dec_ext) ? frwrd - dec_ext : '0;  // Clamp at zero
  end

  //////////////////////////////
  // Heading error to PID
  //////////////////////////////
  assign nudge_ext = HEADING_W'(bus.cfg.nudge);
  assign err_nudge = lft_sync  ? nudge_ext  :           // Veering right, pull left
                     rght_sync ? -nudge_ext :
                     '0;
  assign error     = heading - desired_q + err_nudge;
  assign err_abs   = error[HEADING_W-1] ? -error : error;  // Unsigned view covers -2^(N-1)

  //////////////////////////////
  // FSM
  //////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      state <= S_IDLE;
    else
      state <= nxt_state;
  end

  always_comb begin
    nxt_state       = state;
    strt_cal        = 1'b0;
    tour_go         = 1'b0;
    fanfare_go      = 1'b0;
    reject          = 1'b0;
    clr_frwrd       = 1'b0;
    bus.clr_cmd_rdy = 1'b0;
    bus.send_resp   = 1'b0;
    case (state)
      S_IDLE: begin
        if (bus.cmd_rdy) begin
          bus.clr_cmd_rdy = 1'b1;         // Every opcode is taken at once
          case (op_cur)
            OP_CAL: begin
              strt_cal  = 1'b1;
              nxt_state = S_CAL;
            end
            OP_MOVE, OP_FANFARE: nxt_state = S_ALIGN;
            OP_TOUR: tour_go = 1'b1;      // Sequencer reports on its own
            default: begin
              bus.send_resp = 1'b1;       // Unknown opcode answered now
              reject        = 1'b1;
            end
          endcase
        end
      end
      S_CAL: begin
        if (cal_done) begin
          bus.send_resp = 1'b1;
          nxt_state     = S_IDLE;
        end
      end
      S_ALIGN: begin
        if (err_abs < HEADING_W'(bus.cfg.err_thresh)) begin
          clr_frwrd = 1'b1;
          nxt_state = S_RAMP_UP;
        end
      end
      S_RAMP_UP: begin
        if (move_done) begin
          fanfare_go = (op_q == OP_FANFARE);
          nxt_state  = S_RAMP_DN;
        end
      end
      S_RAMP_DN: begin
        if (spd_zero) begin
          bus.send_resp = 1'b1;
          nxt_state     = S_IDLE;
        end
      end
      default: nxt_state = S_IDLE;
    endcase
  end

  assign moving = (state == S_RAMP_UP) || (state == S_RAMP_DN);

  idle_stopped: assert property (@(posedge clk) disable iff (!rst_n)
    state == S_IDLE |-> frwrd == '0);

  // A command other than Fanfare never sounds the fanfare before the next Idle
  fanfare_only: assert property (@(posedge clk) disable iff (!rst_n)
    accept && op_cur != OP_FANFARE |=> !fanfare_go until state == S_IDLE);

endmodule

// File: hdl/knight_ctrl_top.sv
`timescale 1ns/1ps

module knight_ctrl_top #(
  parameter int HEADING_W   = 12,
  parameter int SPD_W       = 10,
  parameter int SYNC_STAGES = 2
) (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              wb_cyc,
  input  logic                              wb_stb,
  input  logic                              wb_we,
  input  logic [knight_cmd_pkg::ADDR_W-1:0] wb_adr,
  input  logic [knight_cmd_pkg::CMD_W-1:0]  wb_dat_w,
  output logic [knight_cmd_pkg::CMD_W-1:0]  wb_dat_r,
  output logic                              wb_ack,
  output logic                              strt_cal,
  input  logic                              cal_done,
  input  logic signed [HEADING_W-1:0]       heading,
  input  logic                              heading_rdy,
  input  logic                              lft_ir,
  input  logic                              cntr_ir,
  input  logic                              rght_ir,
  output logic signed [HEADING_W-1:0]       error,
  output logic [SPD_W-1:0]                  frwrd,
  output logic                              moving,
  output logic                              tour_go,
  output logic                              fanfare_go
);

  logic lft_sync;
  logic rght_sync;
  logic cntr_rise;                        // Line crossing pulse
  logic reject;                           // Unknown opcode flag to STATUS

  cmd_if u_cmd_bus ();

  motion_cfg_regs u_regs (
    .clk      (clk),
    .rst_n    (rst_n),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_dat_r (wb_dat_r),
    .wb_ack   (wb_ack),
    .reject   (reject),
    .bus      (u_cmd_bus)
  );

  ir_sync #(.SYNC_STAGES(SYNC_STAGES)) u_ir_sync (
    .clk       (clk),
    .rst_n     (rst_n),
    .lft_ir    (lft_ir),
    .cntr_ir   (cntr_ir),
    .rght_ir   (rght_ir),
    .lft_sync  (lft_sync),
    .rght_sync (rght_sync),
    .cntr_rise (cntr_rise)
  );

  cmd_proc #(.HEADING_W(HEADING_W), .SPD_W(SPD_W)) u_cmd_proc (
    .clk         (clk),
    .rst_n       (rst_n),
    .bus         (u_cmd_bus),
    .cal_done    (cal_done),
    .heading     (heading),
    .heading_rdy (heading_rdy),
    .lft_sync    (lft_sync),
    .rght_sync   (rght_sync),
    .cntr_rise   (cntr_rise),
    .strt_cal    (strt_cal),
    .moving      (moving),
    .tour_go     (tour_go),
    .fanfare_go  (fanfare_go),
    .reject      (reject),
    .error       (error),
    .frwrd       (frwrd)
  );

endmodule

// File: verification/tb_clk_rst.sv
`timescale 1ns/1ps

module tb_clk_rst #(
  parameter int PERIOD_NS  = 100,
  parameter int RST_CYCLES = 3
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS/2) clk = ~clk;    // 100 ns period
  end

  initial begin
    rst_n = 1'b0;                         // Held over the first cycles
    repeat (RST_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;                         // Released away from the active edge
  end

endmodule

// File: verification/tb_knight_ctrl.sv
`timescale 1ns/1ps

module tb_knight_ctrl;
  import knight_cmd_pkg::*;

  localparam int HEADING_W   = 12;
  localparam int SPD_W       = 10;
  localparam int SYNC_STAGES = 2;
  localparam int N_RB        = 8;         // Readback rounds
  localparam int N_ERR       = 16;        // Heading samples
  localparam int STEP_MIN    = 16;        // Lowest ramp step used in moves
  localparam int MAX_SQ      = 3;
  localparam int ACK_WAIT    = 8;
  localparam int BUS_CYC     = 4;         // Drive, ack, idle, next drive
  localparam int MOVE_CYC    = 8*BUS_CYC + 20 + (768/STEP_MIN + 2)
                               + 2*MAX_SQ*(SYNC_STAGES + 5) + (1024/STEP_MIN + 2);
  localparam int LIMIT       = 2*N_RB*BUS_CYC + (8*BUS_CYC + 16)
                               + (24*BUS_CYC + N_ERR*(SYNC_STAGES + 2))
                               + 2*MOVE_CYC + 4*BUS_CYC + 6*BUS_CYC + 200;

  logic                 clk;
  logic                 rst_n;
  logic                 wb_cyc, wb_stb, wb_we;
  logic [1:0]           wb_adr;
  logic [15:0]          wb_dat_w, wb_dat_r;
  logic                 wb_ack;
  logic                 strt_cal, cal_done;
  logic [HEADING_W-1:0] heading;
  logic                 heading_rdy;
  logic                 lft_ir, cntr_ir, rght_ir;
  logic [HEADING_W-1:0] error;
  logic [SPD_W-1:0]     frwrd;
  logic                 moving, tour_go, fanfare_go;

  integer      seed = 72672;
  int          errors, checks, n_tests, n_failed, test_err0, cycles;
  int          n_cal, n_tour, n_fan;      // Pulse counts seen at negedge
  logic [7:0]  inc_m, dec_m;              // Tuning as written by the host
  logic [10:0] nudge_m;
  logic [15:0] rd;
  logic [15:0] status;                    // STATUS polled while a move settles
  logic [3:0]  bad_op;
  int          i;
  int          polls;

  tb_clk_rst #(.PERIOD_NS(100), .RST_CYCLES(3)) u_clk_rst (.clk(clk), .rst_n(rst_n));

  knight_ctrl_top #(
    .HEADING_W(HEADING_W), .SPD_W(SPD_W), .SYNC_STAGES(SYNC_STAGES)
  ) u_dut (
    .clk(clk), .rst_n(rst_n), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
    .wb_adr(wb_adr), .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
    .strt_cal(strt_cal), .cal_done(cal_done), .heading(heading),
    .heading_rdy(heading_rdy), .lft_ir(lft_ir), .cntr_ir(cntr_ir), .rght_ir(rght_ir),
    .error(error), .frwrd(frwrd), .moving(moving), .tour_go(tour_go),
    .fanfare_go(fanfare_go)
  );

  //////////////////////////////
  // Monitors and watchdog
  //////////////////////////////
  always @(negedge clk) begin
    if (rst_n) begin
      n_cal  = n_cal + strt_cal;          // Pulses are a full cycle wide
      n_tour = n_tour + tour_go;
      n_fan  = n_fan + fanfare_go;
    end
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= LIMIT) begin
      $display("Run stopped after %0d cycles, a test never completed", cycles);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  //////////////////////////////
  // Checks and reference model
  //////////////////////////////
  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error: %s = 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic report_fail(input string what);
    errors++;
    $display("%s at %0t", what, $time);
  endtask

  task automatic finish_test(input string name);
    n_tests++;
    if (errors != test_err0)
      n_failed++;
    $display("Test %0d %-16s %s", n_tests, name, (errors == test_err0) ? "ok" : "failed");
    test_err0 = errors;
  endtask

  function automatic logic [11:0] desired_of(input logic [7:0] hbyte);
    return (hbyte == 8'h00) ? 12'h000 : {hbyte, 4'hF};  // Byte then 0xF
  endfunction

  function automatic logic [11:0] error_of(input logic [11:0] hdg, input logic [11:0] want,
                                          input logic lft, input logic rght);
    logic [11:0] nud;
    nud = lft ? {1'b0, nudge_m} : rght ? -{1'b0, nudge_m} : 12'h000;
    return hdg - want + nud;
  endfunction

  function automatic logic [9:0] speed_up(input logic [9:0] spd);
    logic [10:0] sum;
    sum = {1'b0, spd} + inc_m;
    if (spd[9] && spd[8])
      return spd;                         // Cruise speed reached
    return sum[10] ? 10'h3FF : sum[9:0];
  endfunction

  function automatic logic [9:0] speed_down(input logic [9:0] spd);
    return (spd > dec_m) ? spd - dec_m : 10'h000;
  endfunction

  //////////////////////////////
  // Wishbone host
  //////////////////////////////
  task automatic wb_access(input logic we, input logic [1:0] adr, input logic [15:0] wdat,
                           output logic [15:0] rdat);
    int waits;
    int acks;
    waits = 0;
    acks  = 0;
    rdat  = '0;
    @(negedge clk);
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_w = wdat;
    do begin
      @(negedge clk);
      waits++;
    end while (!wb_ack && waits < ACK_WAIT);
    if (wb_ack) begin
      acks++;
      rdat = wb_dat_r;                    // Valid with ack
    end else
      report_fail($sformatf("No ack for access to address %0d", adr));
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
    @(negedge clk);
    if (wb_ack)
      acks++;
    check_val("wb_ack count", acks, 1);
  endtask

  task automatic wb_write(input logic [1:0] adr, input logic [15:0] wdat);
    logic [15:0] unused;
    wb_access(1'b1, adr, wdat, unused);
  endtask

  task automatic expect_status(input logic [15:0] exp);
    logic [15:0] st;
    wb_access(1'b0, REG_STATUS, 16'h0000, st);
    check_val("STATUS", st, exp);
  endtask

  //////////////////////////////
  // Move sequence
  //////////////////////////////
  task automatic run_move(input logic [3:0] op, input logic [3:0] squares);
    logic [7:0] hbyte;
    logic [9:0] spd;
    int         fan0;
    int         waits;
    int         k;
    hbyte   = $random(seed);
    heading = desired_of(hbyte);          // Zero error lets Align pass at once
    lft_ir  = 1'b0;
    rght_ir = 1'b0;
    fan0    = n_fan;
    wb_write(REG_CMD, {op, hbyte, squares});
    waits = 0;
    while (!moving && waits < 20) begin
      @(negedge clk);
      waits++;
    end
    if (!moving) begin
      report_fail("moving never rose after the move command");
      return;
    end
    spd = '0;
    check_val("frwrd", frwrd, spd);
    while (!(spd[9] && spd[8])) begin     // Ramp-up, one step per sample
      heading_rdy = 1'b1;
      @(negedge clk);
      heading_rdy = 1'b0;
      spd = speed_up(spd);
      check_val("frwrd", frwrd, spd);
    end
    for (k = 0; k < 2*squares; k++) begin
      cntr_ir = 1'b1;
      repeat (2) @(negedge clk);
      cntr_ir = 1'b0;
      repeat (SYNC_STAGES + 2) @(negedge clk);
      if (k < 2*squares - 1) begin        // A sample here must not slow down
        heading_rdy = 1'b1;
        @(negedge clk);
        heading_rdy = 1'b0;
        check_val("frwrd", frwrd, spd);
        check_val("moving", moving, 1);
      end
    end
    repeat (2) @(negedge clk);
    if (n_fan != fan0 + (op == OP_FANFARE))
      report_fail($sformatf("fanfare_go fired %0d times in one move", n_fan - fan0));
    while (spd != '0) begin               // Ramp-down
      heading_rdy = 1'b1;
      @(negedge clk);
      heading_rdy = 1'b0;
      spd = speed_down(spd);
      check_val("frwrd", frwrd, spd);
    end
    @(negedge clk);
    check_val("moving", moving, 0);
    expect_status(16'h0002);
    wb_write(REG_STATUS, 16'h0002);
  endtask

  //////////////////////////////
  // Test sequence
  //////////////////////////////
  initial begin
    wb_cyc      = 1'b0;
    wb_stb      = 1'b0;
    wb_we       = 1'b0;
    wb_adr      = '0;
    wb_dat_w    = '0;
    cal_done    = 1'b0;
    heading     = '0;
    heading_rdy = 1'b0;
    lft_ir      = 1'b0;
    cntr_ir     = 1'b0;
    rght_ir     = 1'b0;
    {errors, checks, n_tests, n_failed, test_err0, cycles} = '0;
    {n_cal, n_tour, n_fan} = '0;
    @(posedge rst_n);

    for (i = 0; i < N_RB; i++) begin      // 1: register readback
      {dec_m, inc_m} = $random(seed);
      nudge_m = $random(seed);
      wb_write(REG_RAMP, {dec_m, inc_m});
      wb_write(REG_NUDGE, {5'h1F, nudge_m});  // Upper bits are not stored
      wb_access(1'b0, REG_RAMP, 16'h0000, rd);
      check_val("RAMP", rd, {dec_m, inc_m});
      wb_access(1'b0, REG_NUDGE, 16'h0000, rd);
      check_val("NUDGE", rd, {5'h00, nudge_m});
    end
    finish_test("readback");

    wb_write(REG_CMD, {OP_CAL, 12'($random(seed))});  // 2: calibrate
    check_val("strt_cal pulses", n_cal, 1);
    expect_status(16'h0000);
    repeat (1 + {$random(seed)} % 16) @(negedge clk);
    cal_done = 1'b1;
    @(negedge clk);
    cal_done = 1'b0;
    expect_status(16'h0002);
    wb_write(REG_STATUS, 16'h0002);
    expect_status(16'h0000);
    finish_test("calibrate");

    rd = {OP_MOVE, 8'($random(seed)), 4'h0};  // 3: heading error, no squares
    wb_write(REG_CMD, rd);
    for (i = 0; i < N_ERR; i++) begin
      heading = $random(seed);
      case ({$random(seed)} % 3)
        0: {lft_ir, rght_ir} = 2'b00;
        1: {lft_ir, rght_ir} = 2'b10;
        default: {lft_ir, rght_ir} = 2'b01;
      endcase
      repeat (SYNC_STAGES + 1) @(negedge clk);
      check_val("error", $unsigned(error),
                error_of(heading, desired_of(rd[11:4]), lft_ir, rght_ir));
    end
    {lft_ir, rght_ir} = 2'b00;
    heading = desired_of(rd[11:4]);       // Let the move settle and finish
    polls = 0;
    do begin
      wb_access(1'b0, REG_STATUS, 16'h0000, status);
      polls++;
    end while (!status[ST_RESP_DONE] && polls < SYNC_STAGES + 6);
    check_val("STATUS", status, 16'h0002);
    wb_write(REG_STATUS, 16'h0002);
    finish_test("heading error");

    inc_m = STEP_MIN + ($random(seed) & 63);  // 4: move ramp
    dec_m = STEP_MIN + ($random(seed) & 63);
    wb_write(REG_RAMP, {dec_m, inc_m});
    run_move(OP_MOVE, 1 + {$random(seed)} % MAX_SQ);
    finish_test("move ramp");

    run_move(OP_FANFARE, 1 + {$random(seed)} % MAX_SQ);  // 5: fanfare and tour
    wb_write(REG_CMD, {OP_TOUR, 12'($random(seed))});
    check_val("tour_go pulses", n_tour, 1);
    expect_status(16'h0000);
    finish_test("fanfare and tour");

    do bad_op = $random(seed);            // 6: unknown opcode
    while (bad_op inside {OP_CAL, OP_MOVE, OP_FANFARE, OP_TOUR});
    wb_write(REG_CMD, {bad_op, 12'($random(seed))});
    expect_status(16'h0006);
    if (n_cal != 1 || n_tour != 1 || n_fan != 1)
      report_fail("A motion pulse fired for an unknown opcode");
    check_val("moving", moving, 0);
    check_val("frwrd", frwrd, 0);
    wb_write(REG_STATUS, 16'h0002);
    expect_status(16'h0000);
    finish_test("unknown opcode");

    $display("Tests %0d, failed %0d, checks %0d, errors %0d", n_tests, n_failed, checks, errors);
    if (errors == 0)
      $display("STATUS: PASS");
    else
      $display("STATUS: FAIL");
    $finish;
  end

endmodule

// File: build.f
hdl/knight_cmd_pkg.sv
hdl/knight_motion_pkg.sv
hdl/cmd_if.sv
hdl/motion_cfg_regs.sv
hdl/ir_sync.sv
hdl/cmd_proc.sv
hdl/knight_ctrl_top.sv
verification/tb_clk_rst.sv
verification/tb_knight_ctrl.sv

// File: Bender.yml
package:
  name: knight_ctrl

sources:
  - hdl/knight_cmd_pkg.sv
  - hdl/knight_motion_pkg.sv
  - hdl/cmd_if.sv
  - hdl/motion_cfg_regs.sv
  - hdl/ir_sync.sv
  - hdl/cmd_proc.sv
  - hdl/knight_ctrl_top.sv
  - target: test
    files:
      - verification/tb_clk_rst.sv
      - verification/tb_knight_ctrl.sv
